//--- files.f
verilog/srpt_pkg.sv
verilog/srpt_entry_builder.sv
verilog/srpt_queue.sv
verilog/srpt_grant_pkts.sv
testbench/srpt_grant_pkts_tb.sv

//--- testbench/srpt_grant_pkts_tb.sv
`timescale 1ns/1ns

module srpt_grant_pkts_tb
   import srpt_pkg::*;
   ();

   logic                   ap_clk;
   logic                   ap_rst;
   logic                   ap_start_i;
   logic                   header_in_empty_i;
   logic [header_size-1:0] header_in_data_i;
   logic                   header_in_read_en_o;
   logic [entry_size-1:0]  head_entry_o;

   // raw lines of the data file
   string lines[$];
   logic  lines_loaded = 1'b0;

   // best accepted entry since the last reset
   logic [entry_size-1:0] model_head;
   int accepted_count;
   int error_count;

   srpt_grant_pkts i_srpt_grant_pkts (
      .ap_clk              (ap_clk),
      .ap_rst              (ap_rst),
      .ap_start_i          (ap_start_i),
      .header_in_empty_i   (header_in_empty_i),
      .header_in_data_i    (header_in_data_i),
      .header_in_read_en_o (header_in_read_en_o),
      .head_entry_o        (head_entry_o)
   );

   // 40 ns period
   initial begin
      ap_clk = 1'b0;
      forever #20 ap_clk = ~ap_clk;
   end

   // bound the run by the length of the data file
   initial begin
      longint limit_ns;
      wait (lines_loaded);
      limit_ns = longint'(lines.size()) * (srpt_max_entries + 20) * 40;
      #(limit_ns);
      $display("simulation timed out after %0d ns, a test did not finish", limit_ns);
      $display("FAIL: see errors above");
      $finish;
   end

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
                  $time, msg, actual, expected);
         error_count++;
      end
   endtask

   function automatic logic [header_size-1:0] build_header(input int peer, input int rpc,
                                                          input int len, input int inc,
                                                          input int off);
      logic [header_size-1:0] h;
      h = '0;
      h[hdr_peer_hi:hdr_peer_lo] = peer;
      h[hdr_rpc_hi:hdr_rpc_lo] = rpc;
      h[hdr_msg_len_hi:hdr_msg_len_lo] = len;
      h[hdr_incoming_hi:hdr_incoming_lo] = inc;
      h[hdr_offset_hi:hdr_offset_lo] = off;
      return h;
   endfunction

   // only a first packet with more to come makes an entry
   task automatic update_model(input int peer, input int rpc, input int len, input int inc,
                               input int off);
      logic [entry_size-1:0] cand;
      if (len > inc && off == 0) begin
         cand = '0;
         cand[peer_hi:peer_lo] = peer;
         cand[rpc_hi:rpc_lo] = rpc;
         cand[recv_pkts_hi:recv_pkts_lo] = 1;
         cand[grntble_pkts_hi:grntble_pkts_lo] = len - 1;
         cand[status_hi:status_lo] = SRPT_ACTIVE;
         accepted_count++;
         // an active entry always beats an empty head
         if (model_head[status_hi:status_lo] != SRPT_ACTIVE ||
             cand[grntble_pkts_hi:grntble_pkts_lo] <
             model_head[grntble_pkts_hi:grntble_pkts_lo]) begin
            model_head = cand;
         end
      end
   endtask

   task automatic apply_reset();
      @(negedge ap_clk);
      ap_rst = 1'b1;
      ap_start_i = 1'b0;
      header_in_empty_i = 1'b1;
      repeat (16) @(negedge ap_clk);
      ap_rst = 1'b0;
      // a header waits while the DUT is not started yet
      header_in_empty_i = 1'b0;
      model_head = empty_entry;
      accepted_count = 0;
      @(posedge ap_clk);
      check_value(header_in_read_en_o, 1'b0, "read strobe while stopped");
      @(negedge ap_clk);
      header_in_empty_i = 1'b1;
      check_value(head_entry_o, empty_entry, "head right after reset");
   endtask

   task automatic drive_header(input int peer, input int rpc, input int len, input int inc,
                               input int off);
      @(negedge ap_clk);
      ap_start_i = 1'b1;
      header_in_empty_i = 1'b0;
      header_in_data_i = build_header(peer, rpc, len, inc, off);
      // consumed on this edge
      @(posedge ap_clk);
      check_value(header_in_read_en_o, 1'b1, "read strobe for a present header");
      update_model(peer, rpc, len, inc, off);
   endtask

   task automatic idle_and_check(input int peer, input int rpc, input int recv,
                                 input int grant, input int status);
      @(negedge ap_clk);
      ap_start_i = 1'b1;
      header_in_empty_i = 1'b1;
      // sort window
      repeat (srpt_max_entries + 2) @(negedge ap_clk);
      check_value(head_entry_o[peer_hi:peer_lo], peer, "head peer");
      check_value(head_entry_o[rpc_hi:rpc_lo], rpc, "head rpc");
      check_value(head_entry_o[recv_pkts_hi:recv_pkts_lo], recv, "head received count");
      check_value(head_entry_o[grntble_pkts_hi:grntble_pkts_lo], grant, "head grantable count");
      check_value(head_entry_o[status_hi:status_lo], status, "head status");
      check_value(head_entry_o, model_head, "head against model");
   endtask

   task automatic stall_with_header(input int cycles, input int peer, input int rpc,
                                    input int len, input int inc, input int off);
      logic [entry_size-1:0] held;
      @(negedge ap_clk);
      ap_start_i = 1'b0;
      header_in_empty_i = 1'b0;
      header_in_data_i = build_header(peer, rpc, len, inc, off);
      held = head_entry_o;
      repeat (cycles) begin
         @(posedge ap_clk);
         check_value(header_in_read_en_o, 1'b0, "read strobe during stall");
         @(negedge ap_clk);
         check_value(head_entry_o, held, "head frozen during stall");
      end
      // waiting header goes in once ap_start is back
      ap_start_i = 1'b1;
      @(posedge ap_clk);
      check_value(header_in_read_en_o, 1'b1, "read strobe after stall");
      update_model(peer, rpc, len, inc, off);
   endtask

   initial begin
      int fd;
      int n;
      int a, b, c, d, e, f;
      int test_num;
      int pass_count;
      int fail_count;
      int errs_before;
      string line;
      string cmd;

      ap_rst = 1'b1;
      ap_start_i = 1'b0;
      header_in_empty_i = 1'b1;
      header_in_data_i = '0;
      model_head = empty_entry;
      accepted_count = 0;
      error_count = 0;
      test_num = 0;
      pass_count = 0;
      fail_count = 0;

      fd = $fopen("testbench/srpt_tb_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the data file testbench/srpt_tb_input.txt");
         $display("FAIL: see errors above");
         $finish;
      end else begin
         while ($fgets(line, fd)) begin
            lines.push_back(line);
         end
         $fclose(fd);
         lines_loaded = 1'b1;

         foreach (lines[i]) begin
            line = lines[i];
            n = $sscanf(line, "%s", cmd);
            // blank lines and comments
            if (n < 1 || cmd.getc(0) == "#") continue;
            errs_before = error_count;
            case (cmd)
               "reset": apply_reset();
               "hdr": begin
                  n = $sscanf(line, "%s %d %d %d %d %d", cmd, a, b, c, d, e);
                  if (n == 6) drive_header(a, b, c, d, e);
                  else begin
                     $display("line %0d: header needs five operands", i + 1);
                     error_count++;
                  end
               end
               "check": begin
                  n = $sscanf(line, "%s %d %d %d %d %d", cmd, a, b, c, d, e);
                  if (n == 6) idle_and_check(a, b, c, d, e);
                  else begin
                     $display("line %0d: check needs five operands", i + 1);
                     error_count++;
                  end
               end
               "stall": begin
                  n = $sscanf(line, "%s %d %d %d %d %d %d", cmd, a, b, c, d, e, f);
                  if (n == 7) stall_with_header(a, b, c, d, e, f);
                  else begin
                     $display("line %0d: stall needs six operands", i + 1);
                     error_count++;
                  end
               end
               default: begin
                  $display("line %0d: unknown command %s", i + 1, cmd);
                  error_count++;
               end
            endcase
            test_num++;
            if (error_count == errs_before) begin
               pass_count++;
               $display("test %0d (%s, line %0d) ok", test_num, cmd, i + 1);
            end else begin
               fail_count++;
               $display("test %0d (%s, line %0d) failed", test_num, cmd, i + 1);
            end
         end

         @(negedge ap_clk);
         header_in_empty_i = 1'b1;
         $display("tests passed %0d, failed %0d, headers accepted since last reset %0d",
                  pass_count, fail_count, accepted_count);
         if (fail_count == 0 && error_count == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

endmodule

//--- testbench/srpt_tb_input.txt
# one command per line, operands decimal
# reset | hdr peer rpc len inc off | check peer rpc recv grant status | stall cycles peer rpc len inc off
reset
check 0 0 0 0 4
# filtered headers, no entry
hdr 5 17 8 8 0
hdr 6 18 4 9 0
hdr 7 19 20 3 64
hdr 8 20 12 0 1
check 0 0 0 0 4
# single entry format
hdr 101 2001 40 10 0
check 101 2001 1 39 6
reset
# back-to-back inserts in arbitrary order
hdr 11 300 50 1 0
hdr 12 301 33 1 0
hdr 13 302 90 2 0
hdr 14 303 21 4 0
hdr 15 304 64 1 0
check 14 303 1 20 6
# new best arrives
hdr 16 305 9 1 0
hdr 17 306 120 1 0
check 16 305 1 8 6
# inserts that do not beat the head
hdr 18 307 77 1 0
hdr 19 308 15 1 0
check 16 305 1 8 6
# stall with a better header waiting
stall 6 20 309 5 1 0
check 20 309 1 4 6
# stall with a worse header waiting
stall 3 21 310 200 3 0
check 20 309 1 4 6
reset
check 0 0 0 0 4

//--- verilog/srpt_entry_builder.sv
`timescale 1ns/1ns

module srpt_entry_builder
   import srpt_pkg::*;
   (
   input  logic                  ap_start_i,
   input  logic                  header_in_empty_i,
   input  logic [header_size-1:0] header_in_data_i,
   output logic                  header_in_read_en_o,
   output logic                  insert_en_o,
   output logic [entry_size-1:0] insert_entry_o
   );

   // header fields
   logic [hdr_peer_hi-hdr_peer_lo:0]         hdr_peer;
   logic [hdr_rpc_hi-hdr_rpc_lo:0]           hdr_rpc;
   logic [hdr_msg_len_hi-hdr_msg_len_lo:0]   hdr_msg_len;
   logic [hdr_incoming_hi-hdr_incoming_lo:0] hdr_incoming;
   logic [hdr_offset_hi-hdr_offset_lo:0]     hdr_offset;

   // entry fields before packing
   logic [recv_pkts_hi-recv_pkts_lo:0]       recv_pkts;
   logic [grntble_pkts_hi-grntble_pkts_lo:0] grntble_pkts;

   // first packet of a message that still has more to come
   logic new_msg;

   assign hdr_peer     = header_in_data_i[hdr_peer_hi:hdr_peer_lo];
   assign hdr_rpc      = header_in_data_i[hdr_rpc_hi:hdr_rpc_lo];
   assign hdr_msg_len  = header_in_data_i[hdr_msg_len_hi:hdr_msg_len_lo];
   assign hdr_incoming = header_in_data_i[hdr_incoming_hi:hdr_incoming_lo];
   assign hdr_offset   = header_in_data_i[hdr_offset_hi:hdr_offset_lo];

   // consume a header whenever one is present and we are running
   // source must advance by the next edge
   assign header_in_read_en_o = ap_start_i & ~header_in_empty_i;

   // nothing to grant if the whole message is already incoming
   // only offset zero opens a new entry
   assign new_msg = (hdr_msg_len > hdr_incoming) && (hdr_offset == '0);

   assign insert_en_o = header_in_read_en_o & new_msg;

   // the opening packet counts as received
   assign recv_pkts = {{(recv_pkts_hi - recv_pkts_lo){1'b0}}, 1'b1};

   // remaining packets still to grant
   assign grntble_pkts = hdr_msg_len - 1'b1;

   always_comb begin
      insert_entry_o = '0;
      insert_entry_o[peer_hi:peer_lo] = hdr_peer;
      insert_entry_o[rpc_hi:rpc_lo] = hdr_rpc;
      insert_entry_o[recv_pkts_hi:recv_pkts_lo] = recv_pkts;
      insert_entry_o[grntble_pkts_hi:grntble_pkts_lo] = grntble_pkts;
      // new entries always start active
      insert_entry_o[status_hi:status_lo] = SRPT_ACTIVE;
   end

endmodule

//--- verilog/srpt_grant_pkts.sv
`timescale 1ns/1ns

module srpt_grant_pkts
   import srpt_pkg::*;
   (
   input  logic                   ap_clk,
   input  logic                   ap_rst,
   input  logic                   ap_start_i,
   input  logic                   header_in_empty_i,
   input  logic [header_size-1:0] header_in_data_i,
   output logic                   header_in_read_en_o,
   output logic [entry_size-1:0]  head_entry_o
   );

   // builder to queue
   logic                  insert_en;
   logic [entry_size-1:0] insert_entry;

   // header decode and new-message filter
   srpt_entry_builder i_srpt_entry_builder (
      .ap_start_i          (ap_start_i),
      .header_in_empty_i   (header_in_empty_i),
      .header_in_data_i    (header_in_data_i),
      .header_in_read_en_o (header_in_read_en_o),
      .insert_en_o         (insert_en),
      .insert_entry_o      (insert_entry)
   );

   // sorted store, head goes straight out
   srpt_queue i_srpt_queue (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .ap_start_i     (ap_start_i),
      .insert_en_i    (insert_en),
      .insert_entry_i (insert_entry),
      .head_entry_o   (head_entry_o)
   );

endmodule

//--- verilog/srpt_pkg.sv
package srpt_pkg;

   // queue depth, slot 0 is the head
   localparam int srpt_max_entries = 16;

   // entry layout
   localparam int entry_size = 51;
   localparam int peer_hi = 50;
   localparam int peer_lo = 37;
   localparam int rpc_hi = 36;
   localparam int rpc_lo = 23;
   localparam int recv_pkts_hi = 22;
   localparam int recv_pkts_lo = 13;
   localparam int grntble_pkts_hi = 12;
   localparam int grntble_pkts_lo = 3;
   localparam int status_hi = 2;
   localparam int status_lo = 0;

   // incoming header layout
   localparam int header_size = 80;
   localparam int hdr_peer_hi = 79;
   localparam int hdr_peer_lo = 66;
   localparam int hdr_rpc_hi = 65;
   localparam int hdr_rpc_lo = 52;
   localparam int hdr_msg_len_hi = 51;
   localparam int hdr_msg_len_lo = 42;
   localparam int hdr_incoming_hi = 41;
   localparam int hdr_incoming_lo = 32;
   localparam int hdr_offset_hi = 31;
   localparam int hdr_offset_lo = 0;

   // status codes, a higher code ranks ahead
   typedef enum logic [2:0] {
      SRPT_EMPTY  = 3'd4,
      SRPT_ACTIVE = 3'd6
   } srpt_status_e;

   // free slot: zero fields, status empty
   localparam logic [entry_size-1:0] empty_entry = entry_size'(SRPT_EMPTY) << status_lo;

   // true when a strictly outranks b
   // status first, then fewer grantable packets
   // a tie returns false so the caller keeps its order
   function automatic logic srpt_ranks_ahead(input logic [entry_size-1:0] a,
                                             input logic [entry_size-1:0] b);
      if (a[status_hi:status_lo] != b[status_hi:status_lo]) begin
         return a[status_hi:status_lo] > b[status_hi:status_lo];
      end
      return a[grntble_pkts_hi:grntble_pkts_lo] < b[grntble_pkts_hi:grntble_pkts_lo];
   endfunction

endpackage

//--- verilog/srpt_queue.sv
`timescale 1ns/1ns

module srpt_queue
   import srpt_pkg::*;
   (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  ap_start_i,
   input  logic                  insert_en_i,
   input  logic [entry_size-1:0] insert_entry_i,
   output logic [entry_size-1:0] head_entry_o
   );

   // sorted store, slot 0 best so far
   logic [entry_size-1:0] slots [srpt_max_entries];

   // next state of every slot
   logic [entry_size-1:0] slots_next [srpt_max_entries];

   // 0 sorts pairs (0,1),(2,3)..
   // 1 sorts pairs (1,2),(3,4)..
   logic phase;

   assign head_entry_o = slots[0];

   always_comb begin
      // default hold, untouched edge slots keep their value
      slots_next = slots;

      if (insert_en_i) begin
         // new entry meets the old head
         // old head only stays on top if it strictly wins
         if (srpt_ranks_ahead(slots[0], insert_entry_i)) begin
            slots_next[0] = slots[0];
            slots_next[1] = insert_entry_i;
         end else begin
            slots_next[0] = insert_entry_i;
            slots_next[1] = slots[0];
         end

         // rest of the queue moves down one
         // last slot falls off the end
         for (int i = 2; i < srpt_max_entries; i++) begin
            slots_next[i] = slots[i-1];
         end
      end else if (!phase) begin
         // even phase
         for (int i = 0; i < srpt_max_entries - 1; i += 2) begin
            // swap only on a strict win of the lower slot
            if (srpt_ranks_ahead(slots[i+1], slots[i])) begin
               slots_next[i]   = slots[i+1];
               slots_next[i+1] = slots[i];
            end
         end
      end else begin
         // odd phase, slot 0 holds
         for (int i = 1; i < srpt_max_entries - 1; i += 2) begin
            if (srpt_ranks_ahead(slots[i+1], slots[i])) begin
               slots_next[i]   = slots[i+1];
               slots_next[i+1] = slots[i];
            end
         end
      end
   end

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         // every slot back to empty
         for (int i = 0; i < srpt_max_entries; i++) begin
            slots[i] <= empty_entry;
         end
         phase <= 1'b0;
      end else if (ap_start_i) begin
         slots <= slots_next;

         // inserts do not advance the sort phase
         if (!insert_en_i) begin
            phase <= ~phase;
         end
      end
   end

endmodule
